/* flist.f */
design/rename_pkg.sv
design/map_table.sv
design/reorder_buffer.sv
design/exec_unit.sv
design/cdb_arbiter.sv
design/rename_top.sv
dv/clock_gen.sv
dv/rename_tb.sv

/* Bender.yml */
package:
  name: rename_slice

sources:
  - design/rename_pkg.sv
  - design/map_table.sv
  - design/reorder_buffer.sv
  - design/exec_unit.sv
  - design/cdb_arbiter.sv
  - design/rename_top.sv
  - target: test
    files:
      - dv/clock_gen.sv
      - dv/rename_tb.sv

/* dv/rename_tb.sv */
module rename_tb;

  localparam int ROB_DEPTH  = 8;
  localparam int NUM_CYCLES = 600;
  localparam int NREGS      = rename_pkg::NUM_ARCH_REGS;

  logic clock;
  logic reset;
  logic dispatch_valid;
  rename_pkg::unit_sel_t dispatch_unit;
  rename_pkg::arch_reg_t dispatch_rd;
  rename_pkg::arch_reg_t dispatch_rs1;
  rename_pkg::arch_reg_t dispatch_rs2;
  logic branch_pending;
  logic resolve;
  logic kill;
  logic dispatch_ready;
  rename_pkg::rob_tag_t rs1_tag;
  rename_pkg::rob_tag_t rs2_tag;
  logic rs1_ready;
  logic rs2_ready;
  logic cdb_valid;
  rename_pkg::rob_tag_t cdb_tag;
  logic commit_valid;
  rename_pkg::rob_tag_t commit_tag;
  rename_pkg::arch_reg_t commit_rd;

  int check_errors;
  int timeouts;

  // model map table with a live and a pre-branch copy
  rename_pkg::rob_tag_t live_tag [NREGS];
  logic [NREGS-1:0] live_map;
  logic [NREGS-1:0] live_rdy;
  rename_pkg::rob_tag_t ck_tag [NREGS];
  logic [NREGS-1:0] ck_map;
  logic [NREGS-1:0] ck_rdy;

  // model rob
  rename_pkg::rob_tag_t order_q [$]; // tags in dispatch order
  rename_pkg::arch_reg_t rd_of [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] live_mask;
  logic [ROB_DEPTH-1:0] bcast_mask;
  logic [ROB_DEPTH-1:0] spec_mask;
  rename_pkg::rob_tag_t next_tag;
  rename_pkg::rob_tag_t saved_tag;
  logic bp_prev;
  int rob_count;
  rename_pkg::rob_tag_t head_tag;
  rename_pkg::arch_reg_t head_rd;

  logic exp1_map;
  logic exp1_rdy;
  logic exp2_map;
  logic exp2_rdy;
  rename_pkg::rob_tag_t exp1_tag;
  rename_pkg::rob_tag_t exp2_tag;

  clock_gen #(.PERIOD(4), .RESET_CYCLES(5)) u_clk (.clock, .reset);

  rename_top #(.ROB_DEPTH(ROB_DEPTH), .SHORT_LATENCY(1), .LONG_LATENCY(4)) dut (.*);

  task automatic report_mismatch(input string name, input int got, input int exp);
    check_errors++;
    $display("[FAIL] %0t %s: got %0d, expected %0d", $time, name, got, exp);
  endtask

  task automatic log_error(input string what);
    check_errors++;
    $display("%0t error: %s", $time, what);
  endtask

  // expected lookups where zero and unmapped regs read ready
  assign exp1_tag = live_tag[dispatch_rs1];
  assign exp1_map = dispatch_rs1 != rename_pkg::ZERO_REG && live_map[dispatch_rs1];
  assign exp1_rdy = !exp1_map || live_rdy[dispatch_rs1] || (cdb_valid && cdb_tag == exp1_tag);
  assign exp2_tag = live_tag[dispatch_rs2];
  assign exp2_map = dispatch_rs2 != rename_pkg::ZERO_REG && live_map[dispatch_rs2];
  assign exp2_rdy = !exp2_map || live_rdy[dispatch_rs2] || (cdb_valid && cdb_tag == exp2_tag);

  always @(posedge clock) begin
    logic fire;
    logic retired;
    rename_pkg::rob_tag_t done_tag;
    fire = dispatch_valid && dispatch_ready;
    retired = 1'b0;
    done_tag = '0;
    if (reset) begin
      live_map = '0;
      ck_map = '0;
      order_q.delete();
      live_mask = '0;
      bcast_mask = '0;
      spec_mask = '0;
      next_tag = '0;
      saved_tag = '0;
      bp_prev = 1'b0;
    end else begin
      if (branch_pending && !bp_prev) saved_tag = next_tag; // first speculative slot
      bp_prev = branch_pending;
      if (cdb_valid) bcast_mask[cdb_tag] = 1'b1;
      if (commit_valid && order_q.size() != 0) begin
        done_tag = order_q.pop_front();
        live_mask[done_tag] = 1'b0;
        retired = 1'b1;
      end
      for (int r = 0; r < NREGS; r++) begin
        if (cdb_valid && live_map[r] && live_tag[r] == cdb_tag) live_rdy[r] = 1'b1;
        if (cdb_valid && ck_map[r] && ck_tag[r] == cdb_tag) ck_rdy[r] = 1'b1;
        if (retired && live_map[r] && live_tag[r] == done_tag) live_map[r] = 1'b0;
        if (retired && ck_map[r] && ck_tag[r] == done_tag) ck_map[r] = 1'b0;
      end
      if (fire) begin
        order_q.push_back(next_tag);
        rd_of[next_tag] = dispatch_rd;
        live_mask[next_tag] = 1'b1;
        bcast_mask[next_tag] = 1'b0;
        spec_mask[next_tag] = branch_pending;
        if (dispatch_rd != rename_pkg::ZERO_REG) begin
          live_tag[dispatch_rd] = next_tag;
          live_map[dispatch_rd] = 1'b1;
          live_rdy[dispatch_rd] = 1'b0;
          if (!branch_pending) begin
            ck_tag[dispatch_rd] = next_tag;
            ck_map[dispatch_rd] = 1'b1;
            ck_rdy[dispatch_rd] = 1'b0;
          end
        end
        next_tag = next_tag + 1'b1; // wraps with the rob
      end
      if (kill) begin
        // speculative entries sit at the young end
        while (order_q.size() != 0 && spec_mask[order_q[$]]) begin
          live_mask[order_q[$]] = 1'b0;
          void'(order_q.pop_back());
        end
        next_tag = saved_tag;
        live_tag = ck_tag;
        live_map = ck_map;
        live_rdy = ck_rdy;
      end
      if (resolve) begin
        ck_tag = live_tag;
        ck_map = live_map;
        ck_rdy = live_rdy;
      end
      if (resolve || kill) spec_mask = '0;
    end
    rob_count = order_q.size();
    head_tag = (rob_count != 0) ? order_q[0] : '0;
    head_rd = rd_of[head_tag];
  end

  // outputs right after reset
  a_rst_cdb: assert property (@(posedge clock) $fell(reset) |-> !cdb_valid)
    else report_mismatch("cdb_valid", $sampled(cdb_valid), 0);
  a_rst_commit: assert property (@(posedge clock) $fell(reset) |-> !commit_valid)
    else report_mismatch("commit_valid", $sampled(commit_valid), 0);
  a_rst_ready: assert property (@(posedge clock) $fell(reset) |-> dispatch_ready)
    else report_mismatch("dispatch_ready", $sampled(dispatch_ready), 1);

  // in-order commit of broadcast tags
  a_commit_some: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> rob_count != 0)
    else log_error("commit while the model ROB is empty");
  a_commit_tag: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> commit_tag == head_tag)
    else report_mismatch("commit_tag", $sampled(commit_tag), $sampled(head_tag));
  a_commit_rd: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> commit_rd == head_rd)
    else report_mismatch("commit_rd", $sampled(commit_rd), $sampled(head_rd));
  a_commit_done: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> bcast_mask[commit_tag])
    else log_error("a tag committed before it was broadcast");

  // one broadcast per live tag and none for killed ones
  a_cdb_live: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> live_mask[cdb_tag])
    else log_error("broadcast of a tag that is not in flight");
  a_cdb_once: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> !bcast_mask[cdb_tag])
    else log_error("a tag was broadcast twice");

  a_full: assert property (@(posedge clock) disable iff (reset)
    rob_count >= ROB_DEPTH |-> !dispatch_ready)
    else report_mismatch("dispatch_ready", $sampled(dispatch_ready), 0);

  // source lookups
  a_rs1_rdy: assert property (@(posedge clock) disable iff (reset) rs1_ready == exp1_rdy)
    else report_mismatch("rs1_ready", $sampled(rs1_ready), $sampled(exp1_rdy));
  a_rs1_tag: assert property (@(posedge clock) disable iff (reset)
    exp1_map |-> rs1_tag == exp1_tag)
    else report_mismatch("rs1_tag", $sampled(rs1_tag), $sampled(exp1_tag));
  a_rs2_rdy: assert property (@(posedge clock) disable iff (reset) rs2_ready == exp2_rdy)
    else report_mismatch("rs2_ready", $sampled(rs2_ready), $sampled(exp2_rdy));
  a_rs2_tag: assert property (@(posedge clock) disable iff (reset)
    exp2_map |-> rs2_tag == exp2_tag)
    else report_mismatch("rs2_tag", $sampled(rs2_tag), $sampled(exp2_tag));

  initial begin
    int branch_left;
    int waited;
    dispatch_valid = 1'b0;
    dispatch_unit = rename_pkg::SHORT_UNIT;
    dispatch_rd = '0;
    dispatch_rs1 = '0;
    dispatch_rs2 = '0;
    branch_pending = 1'b0;
    resolve = 1'b0;
    kill = 1'b0;
    check_errors = 0;
    timeouts = 0;
    branch_left = 0;
    waited = 0;
    void'($urandom(79));

    while (reset && waited < 50) begin
      @(negedge clock);
      waited++;
    end
    if (reset) begin
      timeouts++;
      $display("%0t error: reset was never released", $time);
    end

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(negedge clock);
      resolve = 1'b0;
      kill = 1'b0;
      if (branch_pending) begin
        branch_left--;
        if (branch_left == 0) begin
          branch_pending = 1'b0; // the pulse ends the window
          if ($urandom_range(1) != 0) kill = 1'b1;
          else resolve = 1'b1;
        end
      end else if ($urandom_range(15) == 0) begin
        branch_pending = 1'b1;
        branch_left = 8 + $urandom_range(24);
      end
      dispatch_valid = $urandom_range(2) != 0;
      dispatch_unit = rename_pkg::unit_sel_t'($urandom_range(1));
      dispatch_rd = rename_pkg::arch_reg_t'($urandom_range(7)); // small range for hazards
      dispatch_rs1 = rename_pkg::arch_reg_t'($urandom_range(7));
      dispatch_rs2 = rename_pkg::arch_reg_t'($urandom_range(7));
    end

    // close any open branch
    @(negedge clock);
    dispatch_valid = 1'b0;
    kill = 1'b0;
    resolve = branch_pending;
    branch_pending = 1'b0;
    @(negedge clock);
    resolve = 1'b0;

    // a held branch blocks commit so the rob fills up
    branch_pending = 1'b1;
    waited = 0;
    while (rob_count < ROB_DEPTH && waited < 200) begin
      dispatch_valid = 1'b1;
      dispatch_unit = rename_pkg::unit_sel_t'($urandom_range(1));
      dispatch_rd = rename_pkg::arch_reg_t'($urandom_range(7));
      dispatch_rs1 = rename_pkg::arch_reg_t'($urandom_range(7));
      dispatch_rs2 = rename_pkg::arch_reg_t'($urandom_range(7));
      @(negedge clock);
      waited++;
    end
    if (rob_count < ROB_DEPTH) begin
      timeouts++;
      $display("%0t error: ROB never filled, %0d entries", $time, rob_count);
    end
    repeat (4) @(negedge clock); // dispatch still requested against a full rob
    dispatch_valid = 1'b0;
    branch_pending = 1'b0;
    resolve = 1'b1;
    @(negedge clock);
    resolve = 1'b0;

    // let the rob drain
    waited = 0;
    while (rob_count != 0 && waited < 200) begin
      @(negedge clock);
      waited++;
    end
    if (rob_count != 0) begin
      timeouts++;
      $display("%0t error: ROB did not drain, %0d entries left", $time, rob_count);
    end

    $display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* dv/clock_gen.sv */
module clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // held over the first few rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

/* design/rename_top.sv */
module rename_top #(
  parameter int ROB_DEPTH     = 8,
  parameter int SHORT_LATENCY = 1,
  parameter int LONG_LATENCY  = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  rename_pkg::unit_sel_t dispatch_unit,
  input  rename_pkg::arch_reg_t dispatch_rd,
  input  rename_pkg::arch_reg_t dispatch_rs1,
  input  rename_pkg::arch_reg_t dispatch_rs2,
  input  logic                  branch_pending,
  input  logic                  resolve,
  input  logic                  kill,
  output logic                  dispatch_ready,
  output rename_pkg::rob_tag_t  rs1_tag,
  output rename_pkg::rob_tag_t  rs2_tag,
  output logic                  rs1_ready,
  output logic                  rs2_ready,
  output logic                  cdb_valid,
  output rename_pkg::rob_tag_t  cdb_tag,
  output logic                  commit_valid,
  output rename_pkg::rob_tag_t  commit_tag,
  output rename_pkg::arch_reg_t commit_rd
);

  logic dispatch_fire;
  logic rob_full;
  rename_pkg::rob_tag_t alloc_tag;

  logic short_busy, long_busy;
  logic short_req, long_req;
  logic short_ack, long_ack;
  rename_pkg::rob_tag_t short_tag, long_tag;

  logic sel_busy;
  logic issue_short;
  logic issue_long;

  assign sel_busy = (dispatch_unit == rename_pkg::LONG_UNIT) ? long_busy : short_busy;
  // no dispatch in a kill cycle, the rollback owns the tail
  assign dispatch_ready = !rob_full && !sel_busy && !kill;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign issue_short    = dispatch_fire && dispatch_unit == rename_pkg::SHORT_UNIT;
  assign issue_long     = dispatch_fire && dispatch_unit == rename_pkg::LONG_UNIT;

  map_table u_map (
    .clock, .reset, .rename_en(dispatch_fire), .rd(dispatch_rd), .alloc_tag,
    .rs1(dispatch_rs1), .rs2(dispatch_rs2), .cdb_valid, .cdb_tag,
    .commit_valid, .commit_rd, .commit_tag, .branch_pending, .resolve, .kill,
    .rs1_tag, .rs1_ready, .rs2_tag, .rs2_ready
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clock, .reset, .alloc_en(dispatch_fire), .alloc_rd(dispatch_rd), .cdb_valid, .cdb_tag,
    .branch_pending, .kill, .alloc_tag, .full(rob_full), .commit_valid, .commit_tag,
    .commit_rd
  );

  exec_unit #(.LATENCY(SHORT_LATENCY)) short_unit (
    .clock, .reset, .issue_en(issue_short), .issue_tag(alloc_tag),
    .src1_tag(rs1_tag), .src1_ready(rs1_ready), .src2_tag(rs2_tag), .src2_ready(rs2_ready),
    .branch_pending, .resolve, .kill, .cdb_valid, .cdb_tag, .cdb_ack(short_ack),
    .busy(short_busy), .cdb_req(short_req), .result_tag(short_tag)
  );

  exec_unit #(.LATENCY(LONG_LATENCY)) long_unit (
    .clock, .reset, .issue_en(issue_long), .issue_tag(alloc_tag),
    .src1_tag(rs1_tag), .src1_ready(rs1_ready), .src2_tag(rs2_tag), .src2_ready(rs2_ready),
    .branch_pending, .resolve, .kill, .cdb_valid, .cdb_tag, .cdb_ack(long_ack),
    .busy(long_busy), .cdb_req(long_req), .result_tag(long_tag)
  );

  cdb_arbiter u_arb (
    .clock, .reset, .req_short(short_req), .req_long(long_req),
    .tag_short(short_tag), .tag_long(long_tag), .ack_short(short_ack), .ack_long(long_ack),
    .cdb_valid, .cdb_tag
  );

endmodule

/* design/cdb_arbiter.sv */
module cdb_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_short,
  input  logic                 req_long,
  input  rename_pkg::rob_tag_t tag_short,
  input  rename_pkg::rob_tag_t tag_long,
  output logic                 ack_short,
  output logic                 ack_long,
  output logic                 cdb_valid,
  output rename_pkg::rob_tag_t cdb_tag
);

  logic owner_valid; // a grant is waiting for its req to fall
  logic owner_long;
  logic last_long;   // last winner

  logic free;
  logic pick_long;
  logic grant_short;
  logic grant_long;

  assign free = !owner_valid;

  // on a tie the unit that lost last time wins
  assign pick_long   = req_long && (!req_short || !last_long);
  assign grant_long  = free && pick_long;
  assign grant_short = free && req_short && !pick_long;

  // ack rises with the grant and holds until the req drops
  assign ack_short = grant_short || (owner_valid && !owner_long);
  assign ack_long  = grant_long || (owner_valid && owner_long);

  // one broadcast per grant
  assign cdb_valid = grant_short || grant_long;
  assign cdb_tag   = pick_long ? tag_long : tag_short;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner_valid <= 1'b0;
      owner_long  <= 1'b0;
      last_long   <= 1'b0;
    end else if (cdb_valid) begin
      owner_valid <= 1'b1;
      owner_long  <= pick_long;
      last_long   <= pick_long;
    end else if (owner_valid && !(owner_long ? req_long : req_short)) begin
      owner_valid <= 1'b0; // req fell, ack drops next cycle
    end
  end

  a_one_ack: assert property (@(posedge clock) disable iff (reset)
    !(ack_short && ack_long));

endmodule

/* design/exec_unit.sv */
module exec_unit #(
  parameter int LATENCY = 1
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 issue_en,
  input  rename_pkg::rob_tag_t issue_tag,
  input  rename_pkg::rob_tag_t src1_tag,
  input  logic                 src1_ready,
  input  rename_pkg::rob_tag_t src2_tag,
  input  logic                 src2_ready,
  input  logic                 branch_pending,
  input  logic                 resolve,
  input  logic                 kill,
  input  logic                 cdb_valid,
  input  rename_pkg::rob_tag_t cdb_tag,
  input  logic                 cdb_ack,
  output logic                 busy,
  output logic                 cdb_req,
  output rename_pkg::rob_tag_t result_tag
);

  localparam int CNT_BITS = $clog2(LATENCY + 1);

  typedef logic [CNT_BITS-1:0] lat_cnt_t;

  rename_pkg::unit_state_e state;
  lat_cnt_t cnt_q;
  logic spec_q;

  rename_pkg::rob_tag_t tag_q;
  rename_pkg::rob_tag_t s1_tag_q;
  rename_pkg::rob_tag_t s2_tag_q;
  logic s1_rdy_q;
  logic s2_rdy_q;

  logic wake1;
  logic wake2;
  logic drop;

  assign wake1 = s1_rdy_q || (cdb_valid && cdb_tag == s1_tag_q);
  assign wake2 = s2_rdy_q || (cdb_valid && cdb_tag == s2_tag_q);

  // once acked the tag is already on the cdb, finish the handshake
  assign drop = kill && spec_q &&
                (state == rename_pkg::unit_wait_ops || state == rename_pkg::unit_exec ||
                 (state == rename_pkg::unit_req && !cdb_ack));

  assign busy       = (state != rename_pkg::unit_idle);
  assign cdb_req    = (state == rename_pkg::unit_req);
  assign result_tag = tag_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= rename_pkg::unit_idle;
      cnt_q  <= '0;
      spec_q <= 1'b0;
    end else if (drop) begin
      state  <= rename_pkg::unit_idle;
      spec_q <= 1'b0;
    end else begin
      if (resolve || kill) spec_q <= 1'b0;
      case (state)
        rename_pkg::unit_idle: begin
          if (issue_en) begin
            spec_q <= branch_pending && !resolve;
            cnt_q  <= lat_cnt_t'(LATENCY);
            state  <= (src1_ready && src2_ready) ? rename_pkg::unit_exec
                                                 : rename_pkg::unit_wait_ops;
          end
        end
        rename_pkg::unit_wait_ops: begin
          if (wake1 && wake2) begin
            cnt_q <= lat_cnt_t'(LATENCY);
            state <= rename_pkg::unit_exec;
          end
        end
        rename_pkg::unit_exec: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == 1'b1) state <= rename_pkg::unit_req;
        end
        rename_pkg::unit_req:     if (cdb_ack) state <= rename_pkg::unit_release;
        rename_pkg::unit_release: if (!cdb_ack) state <= rename_pkg::unit_idle;
        default: state <= rename_pkg::unit_idle;
      endcase
    end
  end

  // op payload and operand readiness
  always_ff @(posedge clock) begin
    if (state == rename_pkg::unit_idle && issue_en) begin
      tag_q    <= issue_tag;
      s1_tag_q <= src1_tag;
      s2_tag_q <= src2_tag;
      s1_rdy_q <= src1_ready;
      s2_rdy_q <= src2_ready;
    end else if (state == rename_pkg::unit_wait_ops) begin
      s1_rdy_q <= wake1;
      s2_rdy_q <= wake2;
    end
  end

  a_tag_stable: assert property (@(posedge clock) disable iff (reset)
    cdb_req |=> !cdb_req || $stable(result_tag));

endmodule

/* design/reorder_buffer.sv */
module reorder_buffer #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc_en,
  input  rename_pkg::arch_reg_t alloc_rd,
  input  logic                  cdb_valid,
  input  rename_pkg::rob_tag_t  cdb_tag,
  input  logic                  branch_pending,
  input  logic                  kill,
  output rename_pkg::rob_tag_t  alloc_tag,
  output logic                  full,
  output logic                  commit_valid,
  output rename_pkg::rob_tag_t  commit_tag,
  output rename_pkg::arch_reg_t commit_rd
);

  localparam int CNT_BITS = $clog2(ROB_DEPTH + 1);

  typedef logic [CNT_BITS-1:0] count_t;

  rename_pkg::arch_reg_t rd_mem [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  logic [ROB_DEPTH-1:0] spec_q; // allocated under a pending branch

  rename_pkg::rob_tag_t head;
  rename_pkg::rob_tag_t tail;
  rename_pkg::rob_tag_t saved_tail;
  count_t count;
  count_t spec_cnt;

  rename_pkg::rob_state_e state;
  logic bp_q;
  logic branch_rise;
  logic rollback;
  logic alloc_fire;
  logic commit_fire;
  count_t cdb_offset;

  function automatic rename_pkg::rob_tag_t next_ptr(input rename_pkg::rob_tag_t ptr);
    return (ptr == rename_pkg::rob_tag_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign branch_rise = branch_pending && !bp_q && state == rename_pkg::ckpt_idle;
  assign rollback    = kill && state == rename_pkg::ckpt_held;
  assign alloc_fire  = alloc_en && !rollback;

  // speculative entries wait at the head until the branch resolves
  assign commit_fire  = (count != '0) && done_q[head] && !spec_q[head];
  assign commit_valid = commit_fire;
  assign commit_tag   = head;
  assign commit_rd    = rd_mem[head];

  assign alloc_tag = tail;
  assign full      = (count == count_t'(ROB_DEPTH));

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      spec_cnt <= '0;
      done_q   <= '0;
      spec_q   <= '0;
      bp_q     <= 1'b0;
      state    <= rename_pkg::ckpt_idle;
    end else begin
      bp_q <= branch_pending;
      if (!branch_pending) spec_q <= '0;
      if (alloc_fire) begin
        done_q[tail] <= 1'b0;
        spec_q[tail] <= branch_pending;
      end
      if (cdb_valid) done_q[cdb_tag] <= 1'b1;
      if (commit_fire) head <= next_ptr(head);

      if (rollback) begin
        tail     <= saved_tail; // drop everything allocated since the branch
        count    <= count - spec_cnt - count_t'(commit_fire);
        spec_cnt <= '0;
      end else begin
        if (alloc_fire) tail <= next_ptr(tail);
        count <= count + count_t'(alloc_fire) - count_t'(commit_fire);
        if (!branch_pending) begin
          spec_cnt <= '0;
        end else if (alloc_fire) begin
          spec_cnt <= spec_cnt + 1'b1;
        end
      end

      case (state)
        rename_pkg::ckpt_idle: if (branch_rise) state <= rename_pkg::ckpt_held;
        rename_pkg::ckpt_held: if (kill || !branch_pending) state <= rename_pkg::ckpt_idle;
        default: state <= rename_pkg::ckpt_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_fire) rd_mem[tail] <= alloc_rd;
    if (branch_rise) saved_tail <= tail; // tail before any speculative alloc
  end

  // distance of the broadcast tag from head
  assign cdb_offset = (cdb_tag >= head) ? count_t'(cdb_tag - head)
                                        : count_t'(ROB_DEPTH + cdb_tag - head);

  a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
    alloc_en |-> !full);
  a_cdb_occupied: assert property (@(posedge clock) disable iff (reset)
    cdb_valid |-> cdb_offset < count);

endmodule

/* design/map_table.sv */
module map_table (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rename_en,
  input  rename_pkg::arch_reg_t rd,
  input  rename_pkg::rob_tag_t  alloc_tag,
  input  rename_pkg::arch_reg_t rs1,
  input  rename_pkg::arch_reg_t rs2,
  input  logic                 cdb_valid,
  input  rename_pkg::rob_tag_t  cdb_tag,
  input  logic                 commit_valid,
  input  rename_pkg::arch_reg_t commit_rd,
  input  rename_pkg::rob_tag_t  commit_tag,
  input  logic                 branch_pending,
  input  logic                 resolve,
  input  logic                 kill,
  output rename_pkg::rob_tag_t  rs1_tag,
  output logic                 rs1_ready,
  output rename_pkg::rob_tag_t  rs2_tag,
  output logic                 rs2_ready
);

  // live table, an unmapped entry holds ready
  rename_pkg::rob_tag_t map_tag [rename_pkg::NUM_ARCH_REGS];
  logic [rename_pkg::NUM_ARCH_REGS-1:0] map_rdy;

  // non-speculative copy for one branch
  rename_pkg::rob_tag_t ckpt_tag [rename_pkg::NUM_ARCH_REGS];
  logic [rename_pkg::NUM_ARCH_REGS-1:0] ckpt_rdy;

  rename_pkg::rob_tag_t map_tag_n [rename_pkg::NUM_ARCH_REGS];
  logic [rename_pkg::NUM_ARCH_REGS-1:0] map_rdy_n;
  rename_pkg::rob_tag_t ckpt_tag_n [rename_pkg::NUM_ARCH_REGS];
  logic [rename_pkg::NUM_ARCH_REGS-1:0] ckpt_rdy_n;

  // source lookups with same-cycle cdb forwarding
  assign rs1_tag   = map_tag[rs1];
  assign rs1_ready = (rs1 == rename_pkg::ZERO_REG) || map_rdy[rs1] ||
                     (cdb_valid && cdb_tag == map_tag[rs1]);
  assign rs2_tag   = map_tag[rs2];
  assign rs2_ready = (rs2 == rename_pkg::ZERO_REG) || map_rdy[rs2] ||
                     (cdb_valid && cdb_tag == map_tag[rs2]);

  // next state of both copies, later updates win
  always_comb begin
    map_tag_n  = map_tag;
    map_rdy_n  = map_rdy;
    ckpt_tag_n = ckpt_tag;
    ckpt_rdy_n = ckpt_rdy;
    for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
      if (cdb_valid && map_tag[i] == cdb_tag) map_rdy_n[i] = 1'b1;
      if (cdb_valid && ckpt_tag[i] == cdb_tag) ckpt_rdy_n[i] = 1'b1; // pre-branch producer
    end
    // retire a mapping only if nothing renamed rd since
    if (commit_valid && commit_rd != rename_pkg::ZERO_REG) begin
      if (map_tag[commit_rd] == commit_tag) begin
        map_tag_n[commit_rd] = '0;
        map_rdy_n[commit_rd] = 1'b1;
      end
      if (ckpt_tag[commit_rd] == commit_tag) begin
        ckpt_tag_n[commit_rd] = '0;
        ckpt_rdy_n[commit_rd] = 1'b1;
      end
    end
    if (rename_en && rd != rename_pkg::ZERO_REG) begin
      map_tag_n[rd] = alloc_tag;
      map_rdy_n[rd] = 1'b0;
      if (!branch_pending) begin // speculative renames stay out of the copy
        ckpt_tag_n[rd] = alloc_tag;
        ckpt_rdy_n[rd] = 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
        map_tag[i]  <= '0;
        ckpt_tag[i] <= '0;
      end
      map_rdy  <= '1;
      ckpt_rdy <= '1;
    end else begin
      map_tag <= kill ? ckpt_tag_n : map_tag_n; // roll back to pre-branch state
      map_rdy <= kill ? ckpt_rdy_n : map_rdy_n;
      ckpt_tag <= resolve ? map_tag_n : ckpt_tag_n; // branch done, fresh copy
      ckpt_rdy <= resolve ? map_rdy_n : ckpt_rdy_n;
    end
  end

  a_resolve_kill_excl: assert property (@(posedge clock) disable iff (reset)
    !(resolve && kill));

endmodule

/* design/rename_pkg.sv */
package rename_pkg;

  // architectural register space
  localparam int REG_BITS = 5;
  localparam int NUM_ARCH_REGS = 1 << REG_BITS; // lookup table depth

  typedef logic [REG_BITS-1:0] arch_reg_t;

  localparam arch_reg_t ZERO_REG = '0; // never renamed, always ready

  // rename tag is the rob index, sized for an 8 entry rob
  localparam int TAG_BITS = 3;

  typedef logic [TAG_BITS-1:0] rob_tag_t;

  // execution unit select
  typedef logic unit_sel_t;

  localparam unit_sel_t SHORT_UNIT = 1'b0;
  localparam unit_sel_t LONG_UNIT  = 1'b1;

  // rob branch checkpoint tracker
  typedef enum logic {
    ckpt_idle,
    ckpt_held
  } rob_state_e;

  // functional unit fsm
  typedef enum logic [2:0] {
    unit_idle,
    unit_wait_ops,
    unit_exec,
    unit_req,
    unit_release
  } unit_state_e;

endpackage
